//--- project.f
hw/arena_pkg.sv
hw/scan_ctrl.sv
hw/wall_map.sv
hw/tile_locator.sv
hw/hit_detect.sv
hw/tank_status.sv
hw/arena_top.sv
verif/tb_clock.sv
verif/arena_sva.sv
verif/tb_top.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing --top-module tb_top -f project.f -o sim_top

out=$(./obj_dir/sim_top 2>&1) || true
echo "$out"

echo "$out" | grep -q "SIMULATION PASSED"

//--- verif/tb_top.sv
module tb_top;
	timeunit 1ns;
	timeprecision 1ps;
	import arena_pkg::*;

	localparam int EV_GRANT = 0;
	localparam int EV_DONE = 1;
	localparam int EV_WALL = 2;
	localparam int EV_REVIVE = 3;
	localparam int EV_RESET = 4;
	localparam int CLK_PERIOD = 8;
	localparam int REVIVE_CYCLES = 40;

	logic               clk;
	logic               resetn;
	logic               start;
	logic [1:0]         map_sel;
	tank_t              tanks [N_TANKS];
	bullet_t            bullets [N_TANKS];
	logic [N_TANKS-1:0] tank_grant;
	dir_t               grant_dir;
	dir_t               tank_facing [N_TANKS];
	logic [N_TANKS-1:0] bullet_done;
	logic               wall_hit;
	tile_addr_t         wall_addr;
	logic [N_TANKS-1:0] tank_destroyed;
	score_t             scores [N_TANKS];
	winner_t            winner;
	int                 errors;
	int                 timeouts;
	int                 seed;
	dir_t               rand_dir;
	time                hit_time;

	tb_clock u_tb_clock (.clk(clk), .resetn(resetn));

	arena_top #(.REVIVE_CYCLES(REVIVE_CYCLES)) u_arena_top (
		.clk(clk), .resetn(resetn), .start(start), .map_sel(map_sel), .tanks(tanks),
		.bullets(bullets), .tank_grant(tank_grant), .grant_dir(grant_dir),
		.tank_facing(tank_facing), .bullet_done(bullet_done), .wall_hit(wall_hit),
		.wall_addr(wall_addr), .tank_destroyed(tank_destroyed), .scores(scores),
		.winner(winner)
	);

	function automatic tank_t place_tank(input int col, input int row, input dir_t dir,
		input logic req);
		tank_t t;
		t.x = px_x_t'(21 + 9 * col);
		t.y = px_y_t'(1 + 9 * row);
		t.req = req;
		t.dir = dir;
		t.moving = 1'b0;
		return t;
	endfunction

	task automatic wait_event(input int kind, input int idx, input string what);
		int   n;
		logic seen;
		n = 0;
		seen = 1'b0;
		while (!seen && n < 3000) begin
			@(negedge clk);
			case (kind)
				EV_GRANT: seen = tank_grant[idx];
				EV_DONE: seen = bullet_done[idx];
				EV_WALL: seen = wall_hit;
				EV_REVIVE: seen = !tank_destroyed[idx];
				default: seen = resetn;
			endcase
			n++;
		end
		if (!seen) begin
			$display("timeout at %0t while waiting for %s", $time, what);
			timeouts++;
		end
	endtask

	task automatic check_val(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	initial begin
		errors = 0;
		timeouts = 0;
		seed = 52798;
		start = 1'b0;
		map_sel = 2'd1;
		for (int i = 0; i < N_TANKS; i++) begin
			tanks[i] = place_tank(0, 0, DIR_UP, 1'b0);
			bullets[i] = '0;
		end
		wait_event(EV_RESET, 0, "reset release");
		start = 1'b1;

		// Free tile, wall tile, arena edge and an off-grid tank all request at once.
		rand_dir = dir_t'($random(seed));
		tanks[0] = place_tank(0, 0, DIR_RIGHT, 1'b1);
		tanks[1] = place_tank(0, 1, DIR_RIGHT, 1'b1);
		tanks[2] = place_tank(0, 0, DIR_LEFT, 1'b1);
		tanks[3] = place_tank(0, 2, rand_dir, 1'b1);
		tanks[3].x = px_x_t'(22 + ($random(seed) & 7));
		wait_event(EV_GRANT, 0, "grant of tank 0 toward a free tile");
		wait_event(EV_GRANT, 0, "grant of tank 0 in the next round"); // Tanks 1 to 3 ran.
		check_val("tank_facing[1]", tank_facing[1], DIR_RIGHT);
		check_val("tank_facing[2]", tank_facing[2], DIR_LEFT);
		check_val("tank_facing[3]", tank_facing[3], rand_dir);

		// Bullet 0 erases the wall at tile (1,1), then a tank drives into it.
		tanks[0] = place_tank(12, 12, DIR_UP, 1'b0);
		tanks[1] = place_tank(8, 8, DIR_UP, 1'b0);
		tanks[2] = place_tank(10, 10, DIR_UP, 1'b0);
		tanks[3] = place_tank(10, 4, DIR_UP, 1'b0);
		bullets[0] = '{x: 8'd21, y: 7'd10, active: 1'b1, dir: DIR_RIGHT};
		wait_event(EV_WALL, 0, "wall hit of bullet 0");
		check_val("wall_addr", wall_addr, 8'h11);
		wait_event(EV_DONE, 0, "bullet done of bullet 0");
		bullets[0].active = 1'b0;
		tanks[0] = place_tank(0, 1, DIR_RIGHT, 1'b1);
		wait_event(EV_GRANT, 0, "grant into the erased tile");

		// Tank 2 shoots tank 1 until it wins.
		tanks[0].req = 1'b0;
		tanks[1] = place_tank(4, 4, DIR_RIGHT, 1'b1);
		for (int k = 0; k < 4; k++) begin
			bullets[2] = '{x: 8'd53, y: 7'd37, active: 1'b1, dir: DIR_UP};
			wait_event(EV_DONE, 2, "bullet done of bullet 2");
			bullets[2].active = 1'b0;
			check_val("tank_destroyed[1]", tank_destroyed[1], 1);
			check_val("scores[2]", scores[2], k + 1);
			if (k < 3) begin
				hit_time = $time;
				wait_event(EV_REVIVE, 1, "revive of tank 1");
				check_val("revive cycles", int'(($time - hit_time) / CLK_PERIOD),
					REVIVE_CYCLES);
				wait_event(EV_GRANT, 1, "grant of revived tank 1");
			end
		end
		repeat (2) @(negedge clk);
		check_val("winner", winner, 3'b110);
		bullets[2].active = 1'b1;
		tanks[0].req = 1'b1;
		repeat (100) @(negedge clk);

		$display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- verif/arena_sva.sv
module arena_sva (
	input logic                          clk,
	input logic                          resetn,
	input logic [1:0]                    map_sel,
	input arena_pkg::tank_t              tanks [arena_pkg::N_TANKS],
	input logic [arena_pkg::N_TANKS-1:0] tank_grant,
	input arena_pkg::dir_t               grant_dir,
	input arena_pkg::dir_t               tank_facing [arena_pkg::N_TANKS],
	input logic [arena_pkg::N_TANKS-1:0] bullet_done,
	input logic                          wall_hit,
	input arena_pkg::tile_addr_t         wall_addr,
	input logic [arena_pkg::N_TANKS-1:0] tank_destroyed,
	input arena_pkg::score_t             scores [arena_pkg::N_TANKS],
	input arena_pkg::winner_t            winner
);
	timeunit 1ns;
	timeprecision 1ps;
	import arena_pkg::*;

	logic  erased [256];
	tank_t tanks_q [N_TANKS];

	function automatic logic map_bit(input int c, input int r);
		case (map_sel)
			2'd1: return (c % 2 == 1) && (r % 2 == 1);
			2'd2: return c == 6;
			2'd3: return c == r;
			default: return 1'b0;
		endcase
	endfunction

	// A move is legal only from an aligned tile toward a free tile inside the arena.
	function automatic logic move_legal(input tank_t t);
		int dx;
		int dy;
		int c;
		int r;
		dx = int'(t.x) - 21;
		dy = int'(t.y) - 1;
		if (dx < 0 || dy < 0 || dx % 9 != 0 || dy % 9 != 0 || dx / 9 > 12 || dy / 9 > 12)
			return 1'b0;
		c = dx / 9;
		r = dy / 9;
		case (t.dir)
			DIR_UP: r = r - 1;
			DIR_DOWN: r = r + 1;
			DIR_LEFT: c = c - 1;
			default: c = c + 1;
		endcase
		if (c < 0 || r < 0 || c > 12 || r > 12)
			return 1'b0;
		return !(map_bit(c, r) && !erased[c * 16 + r]);
	endfunction

	always_ff @(posedge clk) begin
		tanks_q <= tanks; // The tank as seen in its address cycle.
		if (!resetn) begin
			for (int a = 0; a < 256; a++)
				erased[a] <= 1'b0;
		end else if (wall_hit) begin
			erased[wall_addr] <= 1'b1;
		end
	end

	for (genvar i = 0; i < N_TANKS; i++) begin : g_tank
		assert property (@(posedge clk) disable iff (!resetn)
			tank_grant[i] |-> move_legal(tanks_q[i]) && !tank_destroyed[i]
				&& grant_dir == tanks_q[i].dir)
			else $error("tank %0d granted an illegal move", i);
		assert property (@(posedge clk) disable iff (!resetn)
			tank_grant[i] |=> tank_facing[i] == $past(grant_dir))
			else $error("tank %0d facing did not follow its request", i);
		assert property (@(posedge clk) disable iff (!resetn)
			scores[i] != $past(scores[i]) |-> scores[i] == $past(scores[i]) + 4'd1)
			else $error("score of tank %0d changed by more than one", i);
	end

	assert property (@(posedge clk) disable iff (!resetn)
		wall_hit |-> map_bit(int'(wall_addr[7:4]), int'(wall_addr[3:0]))
			&& wall_addr[7:4] <= 4'd12 && wall_addr[3:0] <= 4'd12)
		else $error("wall hit reported on a tile that is not a wall");
	assert property (@(posedge clk) disable iff (!resetn) wall_hit |=> bullet_done != '0)
		else $error("wall hit not followed by bullet done");
	assert property (@(posedge clk) disable iff (!resetn)
		winner[2] |-> tank_grant == '0 && bullet_done == '0 && !wall_hit)
		else $error("pulse seen after game over");

endmodule

bind arena_top arena_sva u_arena_sva (.*);

//--- verif/tb_clock.sv
module tb_clock (
	output logic clk,
	output logic resetn
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		resetn = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		resetn = 1'b1; // Released on a falling edge like the rest of the stimulus.
	end

endmodule

//--- hw/arena_top.sv
module arena_top #(
	parameter int WIN_SCORE     = 4,
	parameter int REVIVE_CYCLES = 250000000
) (
	input  logic                          clk,
	input  logic                          resetn,
	input  logic                          start,
	input  logic [1:0]                    map_sel,
	input  arena_pkg::tank_t              tanks [arena_pkg::N_TANKS],
	input  arena_pkg::bullet_t            bullets [arena_pkg::N_TANKS],
	output logic [arena_pkg::N_TANKS-1:0] tank_grant,
	output arena_pkg::dir_t               grant_dir,
	output arena_pkg::dir_t               tank_facing [arena_pkg::N_TANKS],
	output logic [arena_pkg::N_TANKS-1:0] bullet_done,
	output logic                          wall_hit,
	output arena_pkg::tile_addr_t         wall_addr,
	output logic [arena_pkg::N_TANKS-1:0] tank_destroyed,
	output arena_pkg::score_t             scores [arena_pkg::N_TANKS],
	output arena_pkg::winner_t            winner
);
	import arena_pkg::*;

	tank_idx_t            sel_tank;
	tank_idx_t            sel_bullet;
	tank_idx_t            shooter;
	tile_addr_t           store_addr;
	tile_addr_t           tank_target;
	tile_addr_t           bullet_target;
	logic                 store_we;
	logic                 store_load;
	logic                 wall_bit;
	logic                 tank_check;
	logic                 bullet_check;
	logic                 tank_blocked;
	logic                 bullet_offgrid;
	logic                 bullet_at_edge;
	logic                 hit_any;
	logic                 game_over;
	logic [N_TANKS-1:0]   hit;
	px_x_t                tip_x;
	px_y_t                tip_y;

	scan_ctrl u_scan_ctrl (
		.clk(clk), .resetn(resetn), .start(start), .tanks(tanks), .bullets(bullets),
		.tank_destroyed(tank_destroyed), .game_over(game_over), .wall_bit(wall_bit),
		.tank_target(tank_target), .bullet_target(bullet_target),
		.tank_blocked(tank_blocked), .bullet_offgrid(bullet_offgrid),
		.bullet_at_edge(bullet_at_edge), .hit_any(hit_any),
		.sel_tank(sel_tank), .sel_bullet(sel_bullet), .store_addr(store_addr),
		.store_we(store_we), .store_load(store_load), .tank_check(tank_check),
		.bullet_check(bullet_check), .tank_grant(tank_grant), .grant_dir(grant_dir),
		.bullet_done(bullet_done), .wall_hit(wall_hit), .wall_addr(wall_addr)
	);

	wall_map u_wall_map (
		.clk(clk), .map_sel(map_sel), .addr(store_addr), .we(store_we),
		.load(store_load), .q(wall_bit)
	);

	tile_locator u_tile_locator (
		.tanks(tanks), .bullets(bullets), .sel_tank(sel_tank), .sel_bullet(sel_bullet),
		.tank_target(tank_target), .tank_blocked(tank_blocked),
		.bullet_target(bullet_target), .bullet_offgrid(bullet_offgrid),
		.bullet_at_edge(bullet_at_edge), .tip_x(tip_x), .tip_y(tip_y), .shooter(shooter)
	);

	hit_detect u_hit_detect (
		.tanks(tanks), .tank_destroyed(tank_destroyed), .tip_x(tip_x), .tip_y(tip_y),
		.shooter(shooter), .hit(hit), .hit_any(hit_any)
	);

	tank_status #(
		.WIN_SCORE(WIN_SCORE),
		.REVIVE_CYCLES(REVIVE_CYCLES)
	) u_tank_status (
		.clk(clk), .resetn(resetn), .tank_check(tank_check), .bullet_check(bullet_check),
		.sel_tank(sel_tank), .grant_dir(grant_dir), .shooter(shooter), .hit(hit),
		.tank_destroyed(tank_destroyed), .tank_facing(tank_facing), .scores(scores),
		.winner(winner), .game_over(game_over)
	);

endmodule

//--- hw/tank_status.sv
module tank_status #(
	parameter int WIN_SCORE     = 4,
	parameter int REVIVE_CYCLES = 250000000
) (
	input  logic                          clk,
	input  logic                          resetn,
	input  logic                          tank_check,
	input  logic                          bullet_check,
	input  arena_pkg::tank_idx_t          sel_tank,
	input  arena_pkg::dir_t               grant_dir,
	input  arena_pkg::tank_idx_t          shooter,
	input  logic [arena_pkg::N_TANKS-1:0] hit,
	output logic [arena_pkg::N_TANKS-1:0] tank_destroyed,
	output arena_pkg::dir_t               tank_facing [arena_pkg::N_TANKS],
	output arena_pkg::score_t             scores [arena_pkg::N_TANKS],
	output arena_pkg::winner_t            winner,
	output logic                          game_over
);
	import arena_pkg::*;

	localparam int CNT_W = $clog2(REVIVE_CYCLES + 1);

	logic [CNT_W-1:0] revive_cnt [N_TANKS];

	always_ff @(posedge clk) begin
		if (!resetn) begin
			tank_destroyed <= '0;
			for (int j = 0; j < N_TANKS; j++)
				revive_cnt[j] <= '0;
		end else begin
			for (int j = 0; j < N_TANKS; j++) begin
				if (bullet_check && hit[j]) begin
					tank_destroyed[j] <= 1'b1;
					revive_cnt[j] <= '0;
				end else if (tank_destroyed[j]) begin
					if (revive_cnt[j] == CNT_W'(REVIVE_CYCLES - 1))
						tank_destroyed[j] <= 1'b0; // Back in play.
					revive_cnt[j] <= revive_cnt[j] + CNT_W'(1);
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			for (int j = 0; j < N_TANKS; j++) begin
				tank_facing[j] <= DIR_UP;
				scores[j] <= '0;
			end
		end else begin
			if (tank_check)
				tank_facing[sel_tank] <= grant_dir;
			if (bullet_check && |hit)
				scores[shooter] <= scores[shooter] + score_t'(1); // One point per bullet.
		end
	end

	// Counting down leaves the lowest winning tank in the register.
	always_ff @(posedge clk) begin
		if (!resetn) begin
			winner <= '0;
		end else if (!winner[2]) begin
			for (int j = N_TANKS - 1; j >= 0; j--) begin
				if (scores[j] == score_t'(WIN_SCORE))
					winner <= {1'b1, tank_idx_t'(j)};
			end
		end
	end

	assign game_over = winner[2];

endmodule

//--- hw/hit_detect.sv
module hit_detect (
	input  arena_pkg::tank_t              tanks [arena_pkg::N_TANKS],
	input  logic [arena_pkg::N_TANKS-1:0] tank_destroyed,
	input  arena_pkg::px_x_t              tip_x,
	input  arena_pkg::px_y_t              tip_y,
	input  arena_pkg::tank_idx_t          shooter,
	output logic [arena_pkg::N_TANKS-1:0] hit,
	output logic                          hit_any
);
	import arena_pkg::*;

	// The tank box reaches this far from its top left pixel.
	localparam logic [8:0] REACH_X = 9'(TILE_PITCH - 1);
	localparam logic [7:0] REACH_Y = 8'(TILE_PITCH - 1);

	always_comb begin
		for (int j = 0; j < N_TANKS; j++) begin
			hit[j] = (tank_idx_t'(j) != shooter) && !tank_destroyed[j]
				&& (tanks[j].x <= tip_x) && (({1'b0, tanks[j].x} + REACH_X) >= {1'b0, tip_x})
				&& (tanks[j].y <= tip_y) && (({1'b0, tanks[j].y} + REACH_Y) >= {1'b0, tip_y});
		end
	end

	assign hit_any = |hit;

endmodule

//--- hw/tile_locator.sv
module tile_locator (
	input  arena_pkg::tank_t      tanks [arena_pkg::N_TANKS],
	input  arena_pkg::bullet_t    bullets [arena_pkg::N_TANKS],
	input  arena_pkg::tank_idx_t  sel_tank,
	input  arena_pkg::tank_idx_t  sel_bullet,
	output arena_pkg::tile_addr_t tank_target,
	output logic                  tank_blocked,
	output arena_pkg::tile_addr_t bullet_target,
	output logic                  bullet_offgrid,
	output logic                  bullet_at_edge,
	output arena_pkg::px_x_t      tip_x,
	output arena_pkg::px_y_t      tip_y,
	output arena_pkg::tank_idx_t  shooter
);
	import arena_pkg::*;

	tank_t      tk;
	bullet_t    bl;
	logic [4:0] tk_col;
	logic [4:0] tk_row;
	logic [4:0] bl_col;
	logic [4:0] bl_row;

	// Gives the on-grid flag above the tile index for a distance from the origin.
	function automatic logic [4:0] to_tile(input logic [7:0] d);
		logic [7:0] q;
		q = d / 8'(TILE_PITCH);
		return {(d % 8'(TILE_PITCH) == 8'd0) && (q <= 8'(TILE_LAST)), q[3:0]};
	endfunction

	function automatic tile_addr_t step(input tile_t col, input tile_t row, input dir_t d);
		case (d)
			DIR_UP: return {col, row - 4'd1};
			DIR_DOWN: return {col, row + 4'd1};
			DIR_LEFT: return {col - 4'd1, row};
			default: return {col + 4'd1, row};
		endcase
	endfunction

	function automatic logic at_edge(input px_x_t x, input px_y_t y, input dir_t d);
		case (d)
			DIR_UP: return y == ARENA_Y0;
			DIR_DOWN: return y == ARENA_Y_MAX;
			DIR_LEFT: return x == ARENA_X0;
			default: return x == ARENA_X_MAX;
		endcase
	endfunction

	assign tk = tanks[sel_tank];
	assign bl = bullets[sel_bullet];
	assign tk_col = to_tile(tk.x - ARENA_X0);
	assign tk_row = to_tile({1'b0, tk.y - ARENA_Y0});
	assign bl_col = to_tile(bl.x - ARENA_X0);
	assign bl_row = to_tile({1'b0, bl.y - ARENA_Y0});

	assign tank_target = step(tk_col[3:0], tk_row[3:0], tk.dir);
	assign tank_blocked = !(tk_col[4] && tk_row[4]) || at_edge(tk.x, tk.y, tk.dir);
	assign bullet_target = step(bl_col[3:0], bl_row[3:0], bl.dir);
	assign bullet_offgrid = !(bl_col[4] && bl_row[4]);
	assign bullet_at_edge = at_edge(bl.x, bl.y, bl.dir);
	assign shooter = sel_bullet;

	// The tip is the leading point of the bullet sprite.
	always_comb begin
		tip_x = bl.x;
		tip_y = bl.y;
		case (bl.dir)
			DIR_UP: tip_x = bl.x + px_x_t'(BULLET_TIP_OFS);
			DIR_DOWN: begin
				tip_x = bl.x + px_x_t'(BULLET_TIP_OFS);
				tip_y = bl.y + px_y_t'(BULLET_TIP_FAR);
			end
			DIR_LEFT: tip_y = bl.y + px_y_t'(BULLET_TIP_OFS);
			default: begin
				tip_x = bl.x + px_x_t'(BULLET_TIP_FAR);
				tip_y = bl.y + px_y_t'(BULLET_TIP_OFS);
			end
		endcase
	end

endmodule

//--- hw/wall_map.sv
module wall_map (
	input  logic                  clk,
	input  logic [1:0]            map_sel,
	input  arena_pkg::tile_addr_t addr,
	input  logic                  we,
	input  logic                  load,
	output logic                  q
);
	import arena_pkg::*;

	logic  mem [256];
	tile_t col;
	tile_t row;
	logic  in_arena;
	logic  pattern;

	assign col = addr[7:4];
	assign row = addr[3:0];
	assign in_arena = (col <= TILE_LAST) && (row <= TILE_LAST);

	always_comb begin
		case (map_sel)
			2'd1: pattern = col[0] && row[0]; // Pillars on odd tiles.
			2'd2: pattern = (col == 4'd6);
			2'd3: pattern = (col == row);
			default: pattern = 1'b0;
		endcase
	end

	// A write outside the load is always an erase.
	always_ff @(posedge clk) begin
		if (we)
			mem[addr] <= load ? (pattern && in_arena) : 1'b0;
		q <= mem[addr];
	end

endmodule

//--- hw/scan_ctrl.sv
module scan_ctrl (
	input  logic                          clk,
	input  logic                          resetn,
	input  logic                          start,
	input  arena_pkg::tank_t              tanks [arena_pkg::N_TANKS],
	input  arena_pkg::bullet_t            bullets [arena_pkg::N_TANKS],
	input  logic [arena_pkg::N_TANKS-1:0] tank_destroyed,
	input  logic                          game_over,
	input  logic                          wall_bit,
	input  arena_pkg::tile_addr_t         tank_target,
	input  arena_pkg::tile_addr_t         bullet_target,
	input  logic                          tank_blocked,
	input  logic                          bullet_offgrid,
	input  logic                          bullet_at_edge,
	input  logic                          hit_any,
	output arena_pkg::tank_idx_t          sel_tank,
	output arena_pkg::tank_idx_t          sel_bullet,
	output arena_pkg::tile_addr_t         store_addr,
	output logic                          store_we,
	output logic                          store_load,
	output logic                          tank_check,
	output logic                          bullet_check,
	output logic [arena_pkg::N_TANKS-1:0] tank_grant,
	output arena_pkg::dir_t               grant_dir,
	output logic [arena_pkg::N_TANKS-1:0] bullet_done,
	output logic                          wall_hit,
	output arena_pkg::tile_addr_t         wall_addr
);
	import arena_pkg::*;

	typedef enum logic [3:0] {
		S_IDLE, S_LOAD, S_TADDR, S_TCHECK, S_BADDR, S_BCHECK, S_ERASE, S_DONE, S_STOP
	} state_t;

	state_t     state;
	state_t     next_state;
	state_t     after_slot;
	tank_idx_t  slot;
	tank_idx_t  next_slot;
	tile_addr_t load_cnt;
	tile_addr_t erase_addr;
	dir_t       dir_q;
	logic       blocked_q;
	logic       tank_skip;

	assign tank_skip = !tanks[slot].req || tanks[slot].moving || tank_destroyed[slot];

	always_comb begin
		next_state = state;
		next_slot = slot;
		// Where the scan goes once the current slot is finished.
		after_slot = (slot == 2'd3) ? ((state == S_TADDR || state == S_TCHECK) ? S_BADDR
			: S_TADDR) : ((state == S_TADDR || state == S_TCHECK) ? S_TADDR : S_BADDR);
		case (state)
			S_IDLE: next_state = start ? S_LOAD : S_IDLE;
			S_LOAD: next_state = (load_cnt == 8'hff) ? S_TADDR : S_LOAD;
			S_TADDR: begin
				next_state = tank_skip ? after_slot : S_TCHECK;
				next_slot = tank_skip ? slot + 2'd1 : slot;
			end
			S_BADDR: begin
				if (!bullets[slot].active) begin
					next_state = after_slot;
					next_slot = slot + 2'd1;
				end else if (tank_destroyed[slot]) begin
					next_state = S_DONE; // The shooter is gone, so its bullet is dropped.
				end else begin
					next_state = S_BCHECK;
				end
			end
			S_BCHECK: begin
				if (wall_bit && !bullet_offgrid) begin
					next_state = S_ERASE;
				end else if (hit_any || bullet_at_edge) begin
					next_state = S_DONE;
				end else begin
					next_state = after_slot;
					next_slot = slot + 2'd1;
				end
			end
			S_ERASE: next_state = S_DONE;
			S_TCHECK, S_DONE: begin
				next_state = after_slot;
				next_slot = slot + 2'd1;
			end
			S_STOP: next_state = S_STOP;
			default: next_state = S_IDLE;
		endcase
		if (game_over)
			next_state = S_STOP;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= S_IDLE;
			slot <= '0;
			load_cnt <= '0;
		end else begin
			state <= next_state;
			slot <= next_slot;
			load_cnt <= (state == S_LOAD) ? load_cnt + 8'd1 : 8'd0;
		end
	end

	// The store answers one cycle after the address, so the request is held for the check.
	always_ff @(posedge clk) begin
		if (state == S_TADDR) begin
			dir_q <= tanks[slot].dir;
			blocked_q <= tank_blocked;
		end
		if (state == S_BADDR)
			erase_addr <= bullet_target;
	end

	always_comb begin
		case (state)
			S_LOAD: store_addr = load_cnt;
			S_BADDR, S_BCHECK: store_addr = bullet_target;
			S_ERASE: store_addr = erase_addr;
			default: store_addr = tank_target;
		endcase
	end

	assign store_we = (state == S_LOAD) || (state == S_ERASE);
	assign store_load = (state == S_LOAD);
	assign tank_check = (state == S_TCHECK);
	assign bullet_check = (state == S_BCHECK);
	assign sel_tank = slot;
	assign sel_bullet = slot;
	assign grant_dir = dir_q;
	assign wall_addr = erase_addr;
	assign wall_hit = (state == S_ERASE) && !game_over;

	always_comb begin
		tank_grant = '0;
		bullet_done = '0;
		tank_grant[slot] = tank_check && !blocked_q && !wall_bit && !game_over;
		bullet_done[slot] = (state == S_DONE) && !game_over;
	end

endmodule

//--- hw/arena_pkg.sv
package arena_pkg;

	typedef logic [7:0] px_x_t;
	typedef logic [6:0] px_y_t;
	typedef logic [3:0] tile_t;
	typedef logic [7:0] tile_addr_t; // Column tile in the upper half, row tile in the lower.
	typedef logic [1:0] dir_t;
	typedef logic [1:0] tank_idx_t;
	typedef logic [3:0] score_t;
	typedef logic [2:0] winner_t; // Valid bit above the tank number.

	typedef struct packed {
		px_x_t x;
		px_y_t y;
		logic  req; // Move request for this scan round.
		dir_t  dir;
		logic  moving; // Still sliding from the last granted move.
	} tank_t;

	typedef struct packed {
		px_x_t x;
		px_y_t y;
		logic  active;
		dir_t  dir;
	} bullet_t;

	localparam dir_t DIR_UP    = 2'd0;
	localparam dir_t DIR_DOWN  = 2'd1;
	localparam dir_t DIR_LEFT  = 2'd2;
	localparam dir_t DIR_RIGHT = 2'd3;

	// Pixel origin of tile 0 and the last aligned positions.
	localparam px_x_t ARENA_X0    = 8'd21;
	localparam px_y_t ARENA_Y0    = 7'd1;
	localparam px_x_t ARENA_X_MAX = 8'd129;
	localparam px_y_t ARENA_Y_MAX = 7'd109;

	localparam int    TILE_PITCH     = 9;
	localparam tile_t TILE_LAST      = 4'd12;
	localparam int    BULLET_TIP_OFS = 4;
	localparam int    BULLET_TIP_FAR = 8;
	localparam int    N_TANKS        = 4;

endpackage
